// File: bench/div_input.txt
# dividend divisor quotient remainder
# all fields hex, one division per line
0064 000a 000a 0000
0007 0003 0002 0001
ffff 0001 ffff 0000
ffff ffff 0001 0000
1234 0000 ffff 1234
0000 0005 0000 0000
0003 0007 0000 0003
8000 0002 4000 0000
ffff 0010 0fff 000f
03e8 0007 008e 0006
abcd 0000 ffff abcd
abcd 0123 0097 0028
7fff 00ff 0080 007f
c350 0064 01f4 0000
0001 0001 0001 0000
0000 0000 ffff 0000
fffe 7fff 0002 0000
ffff 8000 0001 7fff
1000 0003 0555 0001
2710 0011 024c 0004
0100 0100 0001 0000
00ff 0100 0000 00ff
d431 00c8 010f 0079
5555 0003 1c71 0002
9c40 03e7 0028 0028
ffff 000a 1999 0005

// File: bench/div_tb.sv
module div_tb
  import div_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic        clk = 1'b0;
  logic        rst;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  logic [15:0] vec_dividend[$];
  logic [15:0] vec_divisor[$];
  logic [15:0] vec_quotient[$];
  logic [15:0] vec_remainder[$];
  logic [31:0] lfsr_state = 32'h5fdb;
  int          cycle_count = 0;
  int          cycle_limit = 200;

  div_top u_dut (
    .clk     (clk),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  // Taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_delay(output int cycles);
    cycles = 0;
    repeat (2) begin
      lfsr_state = lfsr_next(lfsr_state);
      cycles = (cycles << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int delay;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!(awready && wready));
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      @(posedge clk);
      #1;
    end
    // Random back-pressure on the response.
    draw_delay(delay);
    repeat (delay) begin
      @(posedge clk);
      #1;
    end
    resp   = bresp;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int delay;
    araddr  = addr;
    arvalid = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!arready);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    while (!rvalid) begin
      @(posedge clk);
      #1;
    end
    draw_delay(delay);
    repeat (delay) begin
      @(posedge clk);
      #1;
    end
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic write_checked(input logic [3:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    check_value("bresp", {30'd0, resp}, {30'd0, resp_okay});
  endtask

  task automatic read_checked(input logic [3:0] addr, output logic [31:0] data);
    logic [1:0] resp;
    axil_read(addr, data, resp);
    check_value("rresp", {30'd0, resp}, {30'd0, resp_okay});
  endtask

  task automatic run_vector(input logic [15:0] a, input logic [15:0] b,
                            input logic [15:0] q_exp, input logic [15:0] r_exp);
    logic [31:0] status;
    logic [31:0] data;
    logic [31:0] rebuilt;
    write_checked(addr_operands, {a, b});
    write_checked(addr_control, 32'h1);
    // Lands while the divider runs, so it must be dropped.
    write_checked(addr_operands, {~a, b + 16'h1});
    do begin
      read_checked(addr_status, status);
    end while (status[0]);
    check_value("status", status, {30'd0, (b == 16'h0), 1'b0});
    read_checked(addr_result, data);
    check_value("quotient", {16'h0, data[31:16]}, {16'h0, q_exp});
    check_value("remainder", {16'h0, data[15:0]}, {16'h0, r_exp});
    if (b == 16'h0) begin
      check_value("quotient_zero_div", {16'h0, data[31:16]}, 32'h0000_ffff);
      check_value("remainder_zero_div", {16'h0, data[15:0]}, {16'h0, a});
    end else begin
      rebuilt = {16'h0, data[31:16]} * {16'h0, b} + {16'h0, data[15:0]};
      check_value("q*d+r", rebuilt, {16'h0, a});
      check_value("remainder_below_divisor", {31'd0, data[15:0] < b}, 32'd1);
    end
    read_checked(addr_operands, data);
    check_value("operands", data, {a, b});
  endtask

  initial begin
    int          fd;
    string       line;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] q;
    logic [15:0] r;
    logic [31:0] data;
    logic [1:0]  resp;
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    fd = $fopen("bench/div_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file bench/div_input.txt");
      $display("TESTBENCH FAILED");
      $fatal(1, "missing vector file");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%h %h %h %h", a, b, q, r) == 4) begin
          vec_dividend.push_back(a);
          vec_divisor.push_back(b);
          vec_quotient.push_back(q);
          vec_remainder.push_back(r);
        end
      end
    end
    $fclose(fd);
    if (vec_dividend.size() == 0) begin
      $display("The vector file holds no division vectors");
      $display("TESTBENCH FAILED");
      $fatal(1, "empty vector file");
    end
    cycle_limit = 120 * vec_dividend.size() + 200;

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Cleared state after reset.
    read_checked(addr_result, data);
    check_value("result_after_reset", data, 32'h0);
    read_checked(addr_status, data);
    check_value("status_after_reset", data, 32'h0);

    axil_write(4'h6, 32'h1, resp);
    check_value("bresp_unmapped", {30'd0, resp}, {30'd0, resp_slverr});
    axil_read(4'h3, data, resp);
    check_value("rresp_unmapped", {30'd0, resp}, {30'd0, resp_slverr});
    write_checked(addr_status, 32'h0);

    foreach (vec_dividend[i]) begin
      run_vector(vec_dividend[i], vec_divisor[i], vec_quotient[i], vec_remainder[i]);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: hdl/div_axil_regs.sv
module div_axil_regs
  import div_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [3:0]          awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [31:0]         wdata,
  input  logic                wvalid,
  output logic                wready,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  input  logic [3:0]          araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [31:0]         rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  logic                rready,
  output logic                start,
  output logic [op_width-1:0] dividend,
  output logic [op_width-1:0] divisor,
  input  logic                busy,
  input  logic                done,
  input  logic [op_width-1:0] quotient,
  input  logic [op_width-1:0] remainder
);

  div_word_u operands;
  div_word_u result;
  logic      zero_div;
  logic      core_busy;
  logic      busy_q;
  logic      wr_fire;
  logic      rd_fire;

  function automatic logic is_mapped(input logic [3:0] addr);
    return (addr == addr_operands) || (addr == addr_control) ||
           (addr == addr_status) || (addr == addr_result);
  endfunction

  // Start pulse counts as busy until the FSM leaves its start state.
  assign core_busy = busy | start;
  assign wr_fire = awvalid & awready & wvalid & wready;
  assign rd_fire = arvalid & arready;
  assign dividend = operands.half.hi;
  assign divisor  = operands.half.lo;

  always_ff @(posedge clk) begin
    if (rst) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= awvalid & wvalid & ~bvalid & ~awready;
      wready  <= awvalid & wvalid & ~bvalid & ~awready;
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= is_mapped(awaddr) ? resp_okay : resp_slverr;
    end
    if (wr_fire && (awaddr == addr_operands) && !core_busy) begin
      operands.raw <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      start      <= 1'b0;
      zero_div   <= 1'b0;
      busy_q     <= 1'b0;
      result.raw <= '0;
    end else begin
      start <= wr_fire && (awaddr == addr_control) && wdata[0] && !core_busy;
      busy_q <= core_busy;
      if (start) begin
        zero_div <= 1'b0;
      end else if (done && (divisor == '0)) begin
        zero_div <= 1'b1;
      end
      if (done) begin
        result.half.hi <= quotient;
        result.half.lo <= remainder;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid & ~rvalid & ~arready;
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Status busy falls a cycle after done, once result and flag are held.
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rresp <= is_mapped(araddr) ? resp_okay : resp_slverr;
      case (araddr)
        addr_operands: rdata <= operands.raw;
        addr_status:   rdata <= {30'd0, zero_div, core_busy | busy_q};
        addr_result:   rdata <= result.raw;
        default:       rdata <= '0;
      endcase
    end
  end

  // Responses hold, with stable codes, until accepted.
  a_bvalid_hold: assert property (
    @(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid && $stable(bresp)
  );
  a_rvalid_hold: assert property (
    @(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid && $stable(rdata)
  );

endmodule

// File: hdl/div_control.sv
module div_control (
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  output logic        busy,
  div_ctrl_if.control ctrl
);

  localparam logic [2:0] st_start = 3'd0;
  localparam logic [2:0] st_shift = 3'd1;
  localparam logic [2:0] st_check = 3'd2;
  localparam logic [2:0] st_load  = 3'd3;
  localparam logic [2:0] st_done  = 3'd4;

  logic [2:0] state;
  logic [2:0] state_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_start;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_start: begin
        if (start) begin
          state_next = st_shift;
        end
      end
      st_shift: begin
        state_next = st_check;
      end
      st_check: begin
        // Negative trial keeps the old remainder.
        if (!ctrl.trial_neg) begin
          state_next = st_load;
        end else if (ctrl.count_zero) begin
          state_next = st_done;
        end else begin
          state_next = st_shift;
        end
      end
      st_load: begin
        state_next = ctrl.count_zero ? st_done : st_shift;
      end
      st_done: begin
        state_next = st_start;
      end
      default: begin
        state_next = st_start;
      end
    endcase
  end

  // Strobes decode straight from the state.
  assign ctrl.init  = (state == st_start);
  assign ctrl.shift = (state == st_shift);
  assign ctrl.load  = (state == st_load);
  assign ctrl.done  = (state == st_done);
  assign busy = (state != st_start) && (state != st_done);

  // Start only arrives while the FSM is idle.
  a_start_idle: assert property (
    @(posedge clk) disable iff (rst) start |-> ctrl.init
  );

endmodule

// File: hdl/div_ctrl_if.sv
interface div_ctrl_if;

  logic init;
  logic shift;
  logic load;
  logic done;
  logic trial_neg;
  logic count_zero;

  modport control (
    output init,
    output shift,
    output load,
    output done,
    input  trial_neg,
    input  count_zero
  );

  modport datapath (
    input  init,
    input  shift,
    input  load,
    output trial_neg,
    output count_zero
  );

endinterface

// File: hdl/div_datapath.sv
module div_datapath
  import div_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [op_width-1:0] dividend,
  input  logic [op_width-1:0] divisor,
  output logic [op_width-1:0] quotient,
  output logic [op_width-1:0] remainder,
  div_ctrl_if.datapath        dp
);

  // One extra bit, since a shifted remainder can reach twice the divisor.
  logic [op_width:0]      rem_q;
  logic [op_width-1:0]    quo_q;
  logic [op_width-1:0]    div_q;
  logic [count_width-1:0] count_q;
  logic [op_width+1:0]    trial;

  assign trial = {1'b0, rem_q} - {2'b00, div_q};

  assign dp.trial_neg  = trial[op_width+1];
  assign dp.count_zero = (count_q == '0);
  assign quotient  = quo_q;
  assign remainder = rem_q[op_width-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (dp.init) begin
      count_q <= count_width'(op_width);
    end else if (dp.shift) begin
      count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (dp.init) begin
      rem_q <= '0;
      quo_q <= dividend;
      div_q <= divisor;
    end else if (dp.shift) begin
      // Remainder and quotient shift as one word.
      {rem_q, quo_q} <= {rem_q[op_width-1:0], quo_q, 1'b0};
    end else if (dp.load) begin
      rem_q    <= trial[op_width:0];
      quo_q[0] <= 1'b1;
    end
  end

  // Sequencing never asks for a shift past the last bit.
  a_count_no_underflow: assert property (
    @(posedge clk) disable iff (rst) dp.shift |-> (count_q != '0)
  );

endmodule

// File: hdl/div_pkg.sv
package div_pkg;

  localparam int op_width = 16;
  localparam int count_width = 5;

  // Byte offsets within the 16-byte register window.
  localparam logic [3:0] addr_operands = 4'h0;
  localparam logic [3:0] addr_control  = 4'h4;
  localparam logic [3:0] addr_status   = 4'h8;
  localparam logic [3:0] addr_result   = 4'hc;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Operand word: hi is the dividend, lo the divisor.
  // Result word: hi is the quotient, lo the remainder.
  typedef union packed {
    logic [2*op_width-1:0] raw;
    struct packed {
      logic [op_width-1:0] hi;
      logic [op_width-1:0] lo;
    } half;
  } div_word_u;

endpackage

// File: hdl/div_top.sv
module div_top
  import div_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [3:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [3:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  logic                start;
  logic                busy;
  logic [op_width-1:0] dividend;
  logic [op_width-1:0] divisor;
  logic [op_width-1:0] quotient;
  logic [op_width-1:0] remainder;

  div_ctrl_if ctrl_bus ();

  div_axil_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .start     (start),
    .dividend  (dividend),
    .divisor   (divisor),
    .busy      (busy),
    .done      (ctrl_bus.done),
    .quotient  (quotient),
    .remainder (remainder)
  );

  div_control u_control (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .busy  (busy),
    .ctrl  (ctrl_bus.control)
  );

  div_datapath u_datapath (
    .clk       (clk),
    .rst       (rst),
    .dividend  (dividend),
    .divisor   (divisor),
    .quotient  (quotient),
    .remainder (remainder),
    .dp        (ctrl_bus.datapath)
  );

endmodule

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module div_tb \
  -f vlog.f -o div_sim > sim.log 2>&1 &&
  ./obj_dir/div_sim >> sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

// File: vlog.f
hdl/div_pkg.sv
hdl/div_ctrl_if.sv
hdl/div_control.sv
hdl/div_datapath.sv
hdl/div_axil_regs.sv
hdl/div_top.sv
bench/div_tb.sv
